/* vlog.f */
src/exec_pkg.sv
src/exec_dispatch.sv
src/alu_unit.sv
src/mul_unit.sv
src/wb_arbiter.sv
src/exec_top.sv
testbench/tb_clock.sv
testbench/exec_checker.sv
testbench/exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=exec_tb_sim

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_tb -f vlog.f -o "${SIM_BIN}" > "${BUILD_LOG}" 2>&1
status=$?
if [ ${status} -ne 0 ]; then
  cat "${BUILD_LOG}"
  echo "build failed with status ${status}"
  exit 1
fi

./obj_dir/"${SIM_BIN}" > "${SIM_LOG}" 2>&1
status=$?
cat "${SIM_LOG}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

if grep -q "STATUS: FAIL" "${SIM_LOG}"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "${SIM_LOG}"; then
  echo "simulation ended without a status line"
  exit 1
fi
exit 0

/* testbench/exec_tb.sv */
/*
 * execute stage testbench top
 * random micro-op stream, writeback back-pressure and watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module exec_tb;

  import exec_pkg::*;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int SEQ_W     = 5;
  localparam int PERIOD_NS = 8;

  // op counts per test
  localparam int N_DIRECTED = 6;
  localparam int N_HIGH     = 30;
  localparam int N_ALU      = 60;
  localparam int N_MIXED    = 60;
  localparam int N_STALL    = 200;
  localparam int N_TOTAL    = N_DIRECTED + N_HIGH + N_ALU + N_MIXED + N_STALL;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 200;

  logic                  clk;
  logic                  arst_n;
  logic                  d_val;
  logic                  d_rdy;
  logic [ADDR_W-1:0]     d_pc;
  logic [SEQ_W-1:0]      d_seq_num;
  logic [DATA_W-1:0]     d_op1;
  logic [DATA_W-1:0]     d_op2;
  logic [REG_ADDR_W-1:0] d_waddr;
  rv_uop                 d_uop;
  logic                  w_val;
  logic                  w_rdy;
  logic [ADDR_W-1:0]     w_pc;
  logic [SEQ_W-1:0]      w_seq_num;
  logic [REG_ADDR_W-1:0] w_waddr;
  logic [DATA_W-1:0]     w_wdata;
  logic                  w_wen;

  // stimulus state
  integer            seed;
  integer            bp_seed;
  logic              stall_en;
  logic              test_end;
  int                test_id;
  int                pending;
  int                error_count;
  int                check_count;
  logic [ADDR_W-1:0] next_pc;
  logic [SEQ_W-1:0]  next_seq;
  rv_uop             alu_ops [0:9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                       OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
  rv_uop             mul_ops [0:3] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(5)) u_clock (.clk, .arst_n);

  exec_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEQ_W(SEQ_W)) DUT (
    .clk, .arst_n,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2, .d_waddr, .d_uop,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen
  );

  exec_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEQ_W(SEQ_W)) u_checker (
    .clk, .arst_n,
    .d_val, .d_rdy, .d_pc, .d_seq_num, .d_op1, .d_op2, .d_waddr, .d_uop,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen,
    .test_end, .test_id, .pending, .error_count, .check_count
  );

  // ----------------------------------------------------------------------
  // random helpers
  // ----------------------------------------------------------------------

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic logic [DATA_W-1:0] rand_data();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[DATA_W-1:0];
  endfunction

  // ----------------------------------------------------------------------
  // decode channel driver
  // ----------------------------------------------------------------------

  // holds the op until d_rdy is seen on a rising edge
  task automatic send_op(input rv_uop uop, input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b, input int gap);
    repeat (gap) @(posedge clk);
    d_val     <= 1'b1;
    d_pc      <= next_pc;
    d_seq_num <= next_seq;
    d_op1     <= a;
    d_op2     <= b;
    d_waddr   <= REG_ADDR_W'(rand_below(1 << REG_ADDR_W));
    d_uop     <= uop;
    do
    begin
      @(posedge clk);
    end
    while (!d_rdy);
    d_val    <= 1'b0;
    next_pc  = next_pc + ADDR_W'(4);
    next_seq = next_seq + 1'b1;
  endtask

  task automatic send_random(input int gap);
    if (rand_below(2) == 0)
    begin
      send_op(alu_ops[rand_below(10)], rand_data(), rand_data(), gap);
    end
    else
    begin
      send_op(mul_ops[rand_below(4)], rand_data(), rand_data(), gap);
    end
  endtask

  // drain, then let the checker print the test line
  task automatic finish_test(input int id);
    // pending lags the monitor by one edge, so the last op shows up here
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    test_id  <= id;
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  // writeback stalls 40% of cycles when enabled
  always @(posedge clk)
  begin
    if (stall_en)
    begin
      w_rdy <= ({$random(bp_seed)} % 100) >= 40;
    end
    else
    begin
      w_rdy <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial
  begin
    int i;
    seed      = 32'h19361084;
    bp_seed   = 32'h19361084 ^ 32'h2f6e2b1d;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    d_uop     = OP_ADD;
    w_rdy     = 1'b1;
    stall_en  = 1'b0;
    test_end  = 1'b0;
    test_id   = 0;
    next_pc   = ADDR_W'(32'h1000);
    next_seq  = '0;
    wait (arst_n === 1'b1);
    @(posedge clk);
    // idle after reset, w_val watched by the checker
    repeat (5) @(posedge clk);
    finish_test(1);
    // sign cases and the most negative operand
    send_op(OP_MUL, DATA_W'(3), DATA_W'(5), 0);
    send_op(OP_MUL, DATA_W'(7), DATA_W'(-3), 0);
    send_op(OP_MUL, DATA_W'(-4), DATA_W'(6), 0);
    send_op(OP_MUL, DATA_W'(-8), DATA_W'(-9), 0);
    send_op(OP_MUL, DATA_W'(0), DATA_W'(32'h1234), 0);
    send_op(OP_MUL, {1'b1, {(DATA_W-1){1'b0}}}, DATA_W'(2), 0);
    finish_test(2);
    for (i = 0; i < N_HIGH; i++)
    begin
      send_op(mul_ops[1 + i % 3], rand_data(), rand_data(), 0);
    end
    finish_test(3);
    for (i = 0; i < N_ALU; i++)
    begin
      send_op(alu_ops[i % 10], rand_data(), rand_data(), 0);
    end
    finish_test(4);
    for (i = 0; i < N_MIXED; i++)
    begin
      send_random(0);
    end
    finish_test(5);
    stall_en <= 1'b1;
    for (i = 0; i < N_STALL; i++)
    begin
      send_random(rand_below(3));
    end
    finish_test(6);
    stall_en <= 1'b0;
    // catch late duplicates
    repeat (20) @(posedge clk);
    $display("summary: 6 tests, %0d ops checked, %0d errors", check_count, error_count);
    if (error_count == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // run limit scales with the op count
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d ops outstanding",
      WATCHDOG_CYCLES, pending);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/exec_checker.sv */
/*
 * execute stage scoreboard
 * models each accepted micro-op and matches writeback by tag
 */

`timescale 1ns/1ps
`default_nettype none

module exec_checker #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int SEQ_W  = 5
) (
  input  wire                              clk,
  input  wire                              arst_n,
  // decode channel, observed only
  input  wire                              d_val,
  input  wire                              d_rdy,
  input  wire  [ADDR_W-1:0]                d_pc,
  input  wire  [SEQ_W-1:0]                 d_seq_num,
  input  wire  [DATA_W-1:0]                d_op1,
  input  wire  [DATA_W-1:0]                d_op2,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  d_waddr,
  input  exec_pkg::rv_uop                  d_uop,
  // writeback channel, observed only
  input  wire                              w_val,
  input  wire                              w_rdy,
  input  wire  [ADDR_W-1:0]                w_pc,
  input  wire  [SEQ_W-1:0]                 w_seq_num,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  w_waddr,
  input  wire  [DATA_W-1:0]                w_wdata,
  input  wire                              w_wen,
  // test bookkeeping
  input  wire                              test_end,
  input  int                               test_id,
  output int                               pending,
  output int                               error_count,
  output int                               check_count
);

  import exec_pkg::*;

  // expected records, oldest first
  logic [ADDR_W-1:0]     exp_pc [$];
  logic [SEQ_W-1:0]      exp_seq [$];
  logic [REG_ADDR_W-1:0] exp_waddr [$];
  logic [DATA_W-1:0]     exp_wdata [$];
  logic                  exp_mul [$];

  int errors;
  int checks;
  int test_errors;
  int test_checks;
  logic seen_d;
  logic was_stalled;
  logic [ADDR_W+SEQ_W+REG_ADDR_W+DATA_W:0] held;

  initial
  begin
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_checks = 0;
    seen_d      = 1'b0;
    was_stalled = 1'b0;
    pending     = 0;
    error_count = 0;
    check_count = 0;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // products formed at double width, then the wanted half is taken
  function automatic logic [DATA_W-1:0] model_result(input rv_uop uop,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] sa;
    logic [2*DATA_W-1:0] sb;
    logic [2*DATA_W-1:0] za;
    logic [2*DATA_W-1:0] zb;
    logic [2*DATA_W-1:0] wide;
    logic [DATA_W-1:0]   flip;
    int unsigned         sh;
    sa   = {{DATA_W{a[DATA_W-1]}}, a};
    sb   = {{DATA_W{b[DATA_W-1]}}, b};
    za   = {{DATA_W{1'b0}}, a};
    zb   = {{DATA_W{1'b0}}, b};
    // sign bit flip turns a signed compare into an unsigned one
    flip = {1'b1, {(DATA_W-1){1'b0}}};
    sh   = int'(b % DATA_W);
    case (uop)
      OP_ADD:    wide = za + zb;
      OP_SUB:    wide = za + {{DATA_W{1'b0}}, ~b} + 1'b1;
      OP_AND:    wide = za & zb;
      OP_OR:     wide = za | zb;
      OP_XOR:    wide = za ^ zb;
      OP_SLL:    wide = za << sh;
      OP_SRL:    wide = za >> sh;
      OP_SRA:    wide = sa >> sh;
      OP_SLT:    wide = (2*DATA_W)'((a ^ flip) < (b ^ flip));
      OP_SLTU:   wide = (2*DATA_W)'(a < b);
      OP_MUL:    wide = za * zb;
      OP_MULH:   wide = (sa * sb) >> DATA_W;
      OP_MULHSU: wide = (sa * zb) >> DATA_W;
      OP_MULHU:  wide = (za * zb) >> DATA_W;
      default:   wide = '0;
    endcase
    return wide[DATA_W-1:0];
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "directed multiply signs";
      3:       return "high-half multiplies";
      4:       return "alu operations";
      5:       return "mixed stream";
      6:       return "random back-pressure";
      default: return "unnamed";
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // error helpers
  // ----------------------------------------------------------------------

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_field(input string name, input logic [SEQ_W-1:0] seq,
      input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      note_error($sformatf("[FAIL] %s seq %0h: got %0h expected %0h", name, seq, got, exp));
    end
  endtask

  // oldest pending record with this tag is the match
  task automatic match_writeback();
    int   i;
    int   hit;
    logic older;
    hit   = -1;
    older = 1'b0;
    for (i = 0; i < exp_seq.size(); i++)
    begin
      if (hit < 0 && exp_seq[i] == w_seq_num)
      begin
        hit = i;
      end
    end
    if (hit < 0)
    begin
      note_error($sformatf("writeback of seq %0h at pc %0h matches no outstanding op",
        w_seq_num, w_pc));
      return;
    end
    // same unit must retire in order
    for (i = 0; i < hit; i++)
    begin
      if (exp_mul[i] == exp_mul[hit])
      begin
        older = 1'b1;
      end
    end
    if (older)
    begin
      note_error($sformatf("seq %0h retired ahead of an older op of the same unit",
        w_seq_num));
    end
    check_field("w_pc", w_seq_num, 64'(w_pc), 64'(exp_pc[hit]));
    check_field("w_waddr", w_seq_num, 64'(w_waddr), 64'(exp_waddr[hit]));
    check_field("w_wdata", w_seq_num, 64'(w_wdata), 64'(exp_wdata[hit]));
    check_field("w_wen", w_seq_num, 64'(w_wen), 64'(1'b1));
    exp_pc.delete(hit);
    exp_seq.delete(hit);
    exp_waddr.delete(hit);
    exp_wdata.delete(hit);
    exp_mul.delete(hit);
    checks++;
    test_checks++;
  endtask

  // ----------------------------------------------------------------------
  // channel monitor
  // ----------------------------------------------------------------------

  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      if (w_val !== 1'b0)
      begin
        note_error("w_val is high while reset is asserted");
      end
      seen_d      = 1'b0;
      was_stalled = 1'b0;
    end
    else
    begin
      if (!seen_d && w_val !== 1'b0)
      begin
        note_error("w_val rose before any op was accepted");
      end
      // stalled slot must come back unchanged
      if (was_stalled && (w_val !== 1'b1
          || held !== {w_pc, w_seq_num, w_waddr, w_wdata, w_wen}))
      begin
        note_error("writeback payload changed while w_rdy was low");
      end
      was_stalled = w_val && !w_rdy;
      held        = {w_pc, w_seq_num, w_waddr, w_wdata, w_wen};
      if (w_val && w_rdy)
      begin
        match_writeback();
      end
      if (d_val && d_rdy)
      begin
        exp_pc.push_back(d_pc);
        exp_seq.push_back(d_seq_num);
        exp_waddr.push_back(d_waddr);
        exp_wdata.push_back(model_result(d_uop, d_op1, d_op2));
        exp_mul.push_back(is_mul_op(d_uop));
        seen_d = 1'b1;
      end
    end
    if (test_end)
    begin
      if (exp_seq.size() != 0)
      begin
        note_error($sformatf("%0d ops never came back", exp_seq.size()));
      end
      $display("test %0d %s: %0d ops checked, %0d errors", test_id, test_name(test_id),
        test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    pending     <= exp_seq.size();
    error_count <= errors;
    check_count <= checks;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
/*
 * testbench clock and reset source
 * free-running clock, reset held low for the first cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  // half period per toggle
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a rising edge so the first op lines up with the clock
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* src/exec_top.sv */
/*
 * execute stage top
 * dispatch, alu, multiplier pipe and writeback arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int SEQ_W  = 5
) (
  input  wire                              clk,
  input  wire                              arst_n,
  // decode channel
  input  wire                              d_val,
  output logic                             d_rdy,
  input  wire  [ADDR_W-1:0]                d_pc,
  input  wire  [SEQ_W-1:0]                 d_seq_num,
  input  wire  [DATA_W-1:0]                d_op1,
  input  wire  [DATA_W-1:0]                d_op2,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  d_waddr,
  input  exec_pkg::rv_uop                  d_uop,
  // writeback channel
  output logic                             w_val,
  input  wire                              w_rdy,
  output logic [ADDR_W-1:0]                w_pc,
  output logic [SEQ_W-1:0]                 w_seq_num,
  output logic [exec_pkg::REG_ADDR_W-1:0]  w_waddr,
  output logic [DATA_W-1:0]                w_wdata,
  output logic                             w_wen
);

  import exec_pkg::*;

  // dispatch handshakes
  logic alu_in_val, alu_in_rdy;
  logic mul_in_val, mul_in_rdy;

  // unit result channels
  logic                  alu_out_val, alu_out_rdy;
  logic [ADDR_W-1:0]     alu_out_pc;
  logic [SEQ_W-1:0]      alu_out_seq_num;
  logic [REG_ADDR_W-1:0] alu_out_waddr;
  logic [DATA_W-1:0]     alu_out_wdata;
  logic                  mul_out_val, mul_out_rdy;
  logic [ADDR_W-1:0]     mul_out_pc;
  logic [SEQ_W-1:0]      mul_out_seq_num;
  logic [REG_ADDR_W-1:0] mul_out_waddr;
  logic [DATA_W-1:0]     mul_out_wdata;

  exec_dispatch u_dispatch (
    .d_val, .d_rdy, .d_uop,
    .alu_in_val, .alu_in_rdy,
    .mul_in_val, .mul_in_rdy
  );

  // payload fans out to both units directly
  alu_unit #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEQ_W(SEQ_W)) u_alu (
    .clk, .arst_n,
    .in_val(alu_in_val), .in_rdy(alu_in_rdy), .in_pc(d_pc), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr), .in_uop(d_uop),
    .out_val(alu_out_val), .out_rdy(alu_out_rdy), .out_pc(alu_out_pc),
    .out_seq_num(alu_out_seq_num), .out_waddr(alu_out_waddr), .out_wdata(alu_out_wdata)
  );

  mul_unit #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEQ_W(SEQ_W)) u_mul (
    .clk, .arst_n,
    .in_val(mul_in_val), .in_rdy(mul_in_rdy), .in_pc(d_pc), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr), .in_uop(d_uop),
    .out_val(mul_out_val), .out_rdy(mul_out_rdy), .out_pc(mul_out_pc),
    .out_seq_num(mul_out_seq_num), .out_waddr(mul_out_waddr), .out_wdata(mul_out_wdata)
  );

  wb_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEQ_W(SEQ_W)) u_arb (
    .clk, .arst_n,
    .mul_val(mul_out_val), .mul_rdy(mul_out_rdy), .mul_pc(mul_out_pc),
    .mul_seq_num(mul_out_seq_num), .mul_waddr(mul_out_waddr), .mul_wdata(mul_out_wdata),
    .alu_val(alu_out_val), .alu_rdy(alu_out_rdy), .alu_pc(alu_out_pc),
    .alu_seq_num(alu_out_seq_num), .alu_waddr(alu_out_waddr), .alu_wdata(alu_out_wdata),
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_wdata, .w_wen
  );

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
/*
 * writeback arbiter
 * merges alu and multiplier results into one registered slot
 */

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int SEQ_W  = 5
) (
  input  wire                              clk,
  input  wire                              arst_n,
  // multiplier results, older so served first
  input  wire                              mul_val,
  output logic                             mul_rdy,
  input  wire  [ADDR_W-1:0]                mul_pc,
  input  wire  [SEQ_W-1:0]                 mul_seq_num,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  mul_waddr,
  input  wire  [DATA_W-1:0]                mul_wdata,
  // alu results
  input  wire                              alu_val,
  output logic                             alu_rdy,
  input  wire  [ADDR_W-1:0]                alu_pc,
  input  wire  [SEQ_W-1:0]                 alu_seq_num,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  alu_waddr,
  input  wire  [DATA_W-1:0]                alu_wdata,
  // writeback channel
  output logic                             w_val,
  input  wire                              w_rdy,
  output logic [ADDR_W-1:0]                w_pc,
  output logic [SEQ_W-1:0]                 w_seq_num,
  output logic [exec_pkg::REG_ADDR_W-1:0]  w_waddr,
  output logic [DATA_W-1:0]                w_wdata,
  output logic                             w_wen
);

  logic load;

  // slot is free when empty or drained this cycle
  assign load = !w_val || w_rdy;

  // fixed priority, multiplier first
  assign mul_rdy = load;
  assign alu_rdy = load && !mul_val;

  // ----------------------------------------------------------------------
  // output slot
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      w_val <= 1'b0;
    end
    else if (load)
    begin
      w_val <= mul_val || alu_val;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load && mul_val)
    begin
      w_pc      <= mul_pc;
      w_seq_num <= mul_seq_num;
      w_waddr   <= mul_waddr;
      w_wdata   <= mul_wdata;
      w_wen     <= 1'b1;
    end
    else if (load && alu_val)
    begin
      w_pc      <= alu_pc;
      w_seq_num <= alu_seq_num;
      w_waddr   <= alu_waddr;
      w_wdata   <= alu_wdata;
      // every op in scope writes rd
      w_wen     <= 1'b1;
    end
  end

  // pending writeback keeps its payload until taken
  a_w_stable: assert property (@(posedge clk) disable iff (!arst_n)
    w_val && !w_rdy |=> w_val
      && $stable({w_pc, w_seq_num, w_waddr, w_wdata, w_wen}));

endmodule

`default_nettype wire

/* src/mul_unit.sv */
/*
 * three-stage integer multiplier
 * signed and unsigned 32x32 products, low or high half select
 */

`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int SEQ_W  = 5
) (
  input  wire                              clk,
  input  wire                              arst_n,
  // request from dispatch
  input  wire                              in_val,
  output logic                             in_rdy,
  input  wire  [ADDR_W-1:0]                in_pc,
  input  wire  [SEQ_W-1:0]                 in_seq_num,
  input  wire  [DATA_W-1:0]                in_op1,
  input  wire  [DATA_W-1:0]                in_op2,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  in_waddr,
  input  exec_pkg::rv_uop                  in_uop,
  // result toward the arbiter
  output logic                             out_val,
  input  wire                              out_rdy,
  output logic [ADDR_W-1:0]                out_pc,
  output logic [SEQ_W-1:0]                 out_seq_num,
  output logic [exec_pkg::REG_ADDR_W-1:0]  out_waddr,
  output logic [DATA_W-1:0]                out_wdata
);

  import exec_pkg::*;

  // per-stage valid bits
  logic s1_val, s2_val, s3_val;
  logic advance;

  // stage 1 extended operands and tags
  logic signed [DATA_W:0]     s1_a, s1_b;
  logic                       s1_hi;
  logic [ADDR_W-1:0]          s1_pc;
  logic [SEQ_W-1:0]           s1_seq;
  logic [REG_ADDR_W-1:0]      s1_waddr;

  // stage 2 full product and tags
  logic signed [2*DATA_W-1:0] prod;
  logic [2*DATA_W-1:0]        s2_prod;
  logic                       s2_hi;
  logic [ADDR_W-1:0]          s2_pc;
  logic [SEQ_W-1:0]           s2_seq;
  logic [REG_ADDR_W-1:0]      s2_waddr;

  logic a_signed, b_signed;

  // ----------------------------------------------------------------------
  // pipe control
  // ----------------------------------------------------------------------

  // whole pipe moves together, only when the last slot frees up
  assign advance = !s3_val || out_rdy;
  assign in_rdy  = advance;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_val  <= 1'b0;
      s2_val  <= 1'b0;
      s3_val  <= 1'b0;
    end
    else if (advance)
    begin
      s1_val  <= in_val;
      s2_val  <= s1_val;
      s3_val  <= s2_val;
    end
  end

  assign out_val = s3_val;

  // ----------------------------------------------------------------------
  // stage 1  operand extension
  // ----------------------------------------------------------------------

  // mulhsu treats op2 as unsigned, mul low half does not care
  assign a_signed = (in_uop == OP_MULH) || (in_uop == OP_MULHSU);
  assign b_signed = (in_uop == OP_MULH);

  always_ff @(posedge clk)
  begin
    if (advance && in_val)
    begin
      s1_a     <= {a_signed & in_op1[DATA_W-1], in_op1};
      s1_b     <= {b_signed & in_op2[DATA_W-1], in_op2};
      s1_hi    <= (in_uop != OP_MUL);
      s1_pc    <= in_pc;
      s1_seq   <= in_seq_num;
      s1_waddr <= in_waddr;
    end
  end

  // ----------------------------------------------------------------------
  // stage 2  product
  // ----------------------------------------------------------------------

  // fits in 2*DATA_W bits for every signedness mix
  assign prod = s1_a * s1_b;

  always_ff @(posedge clk)
  begin
    if (advance && s1_val)
    begin
      s2_prod  <= prod;
      s2_hi    <= s1_hi;
      s2_pc    <= s1_pc;
      s2_seq   <= s1_seq;
      s2_waddr <= s1_waddr;
    end
  end

  // ----------------------------------------------------------------------
  // stage 3  half select and result slot
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (advance && s2_val)
    begin
      out_wdata   <= s2_hi ? s2_prod[2*DATA_W-1:DATA_W] : s2_prod[DATA_W-1:0];
      out_pc      <= s2_pc;
      out_seq_num <= s2_seq;
      out_waddr   <= s2_waddr;
    end
  end

  // stall freezes every stage, not just the last
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    s3_val && !out_rdy |=> $stable({s1_val, s2_val, s3_val}) && $stable(s1_a)
      && $stable(s1_b) && $stable(s2_prod) && $stable(out_wdata));

  // no new op enters while the result waits at the output
  a_no_accept: assert property (@(posedge clk) disable iff (!arst_n)
    s3_val && !out_rdy |-> !in_rdy);

endmodule

`default_nettype wire

/* src/alu_unit.sv */
/*
 * single-cycle integer alu
 * rv32i register-register ops with a registered result slot
 */

`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int SEQ_W  = 5
) (
  input  wire                              clk,
  input  wire                              arst_n,
  // request from dispatch
  input  wire                              in_val,
  output logic                             in_rdy,
  input  wire  [ADDR_W-1:0]                in_pc,
  input  wire  [SEQ_W-1:0]                 in_seq_num,
  input  wire  [DATA_W-1:0]                in_op1,
  input  wire  [DATA_W-1:0]                in_op2,
  input  wire  [exec_pkg::REG_ADDR_W-1:0]  in_waddr,
  input  exec_pkg::rv_uop                  in_uop,
  // result toward the arbiter
  output logic                             out_val,
  input  wire                              out_rdy,
  output logic [ADDR_W-1:0]                out_pc,
  output logic [SEQ_W-1:0]                 out_seq_num,
  output logic [exec_pkg::REG_ADDR_W-1:0]  out_waddr,
  output logic [DATA_W-1:0]                out_wdata
);

  import exec_pkg::*;

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W-1:0]  result;

  // shift amount from low bits of op2 only
  assign shamt = in_op2[SHAMT_W-1:0];

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_comb
  begin
    case (in_uop)
      OP_ADD:  result = in_op1 + in_op2;
      OP_SUB:  result = in_op1 - in_op2;
      OP_AND:  result = in_op1 & in_op2;
      OP_OR:   result = in_op1 | in_op2;
      OP_XOR:  result = in_op1 ^ in_op2;
      OP_SLL:  result = in_op1 << shamt;
      OP_SRL:  result = in_op1 >> shamt;
      OP_SRA:  result = $signed(in_op1) >>> shamt;
      OP_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(in_op1) < $signed(in_op2)};
      OP_SLTU: result = {{(DATA_W-1){1'b0}}, in_op1 < in_op2};
      // multiply codes never reach this unit
      default: result = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // output slot
  // ----------------------------------------------------------------------

  // slot can take a new op when empty or being drained
  assign in_rdy = !out_val || out_rdy;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_val <= 1'b0;
    end
    else if (in_rdy)
    begin
      out_val <= in_val;
    end
  end

  // result and tag fields
  always_ff @(posedge clk)
  begin
    if (in_val && in_rdy)
    begin
      out_pc      <= in_pc;
      out_seq_num <= in_seq_num;
      out_waddr   <= in_waddr;
      out_wdata   <= result;
    end
  end

  // held result must not move until the arbiter takes it
  a_hold_wdata: assert property (@(posedge clk) disable iff (!arst_n)
    out_val && !out_rdy |=> out_val && $stable(out_wdata));

endmodule

`default_nettype wire

/* src/exec_dispatch.sv */
/*
 * execute dispatch
 * steers decoded micro-ops to the alu or the multiplier pipe
 */

`timescale 1ns/1ps
`default_nettype none

module exec_dispatch (
  // decode side handshake
  input  wire              d_val,
  output logic             d_rdy,
  input  exec_pkg::rv_uop  d_uop,
  // alu side
  output logic             alu_in_val,
  input  wire              alu_in_rdy,
  // multiplier side
  output logic             mul_in_val,
  input  wire              mul_in_rdy
);

  import exec_pkg::*;

  // ----------------------------------------------------------------------
  // classification
  // ----------------------------------------------------------------------

  logic to_mul;

  // multiply family goes to the pipe, everything else is alu work
  assign to_mul = is_mul_op(d_uop);

  // ----------------------------------------------------------------------
  // steering
  // ----------------------------------------------------------------------

  // only the selected unit sees val
  always_comb
  begin
    alu_in_val = d_val && !to_mul;
    mul_in_val = d_val &&  to_mul;
  end

  // ready comes back from the unit this uop targets
  // a stalled multiplier does not block alu ops and vice versa
  always_comb
  begin
    if (to_mul)
    begin
      d_rdy = mul_in_rdy;
    end
    else
    begin
      d_rdy = alu_in_rdy;
    end
  end

  // payload buses bypass this block and fan out from the top

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
/*
 * execute stage shared definitions
 * micro-op codes, register address width and unit classification
 */

`default_nettype none

package exec_pkg;

  // ----------------------------------------------------------------------
  // register file addressing
  // ----------------------------------------------------------------------

  // rd index width, 32 architectural registers
  localparam int unsigned REG_ADDR_W = 5;

  // ----------------------------------------------------------------------
  // micro-op encoding
  // ----------------------------------------------------------------------

  // register-register alu ops first, multiply family at the top
  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,
    OP_SUB    = 4'h1,
    OP_AND    = 4'h2,
    OP_OR     = 4'h3,
    OP_XOR    = 4'h4,
    OP_SLL    = 4'h5,
    OP_SRL    = 4'h6,
    OP_SRA    = 4'h7,
    OP_SLT    = 4'h8,
    OP_SLTU   = 4'h9,
    OP_MUL    = 4'ha,
    OP_MULH   = 4'hb,
    OP_MULHSU = 4'hc,
    OP_MULHU  = 4'hd
  } rv_uop;

  // true for ops that go to the multiplier pipe
  function automatic logic is_mul_op(input rv_uop uop);
    return uop inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

endpackage

`default_nettype wire
